// ==== cas_mem_defines.svh ====
// Shared sizing constants for the cassette memory path
// CM_CREDITS must be a power of two, since the FIFO pointers wrap freely
// CM_MEM_LAT must be at least 2
// CM_BIT_DIV must be a power of two and at least 2

`ifndef CAS_MEM_DEFINES_SVH
`define CAS_MEM_DEFINES_SVH

// Byte address width of the shared memory
`define CM_ADDR_W 12

// One data byte
`define CM_DATA_W 8

// Credits per link, also the buffer depth on each side
`define CM_CREDITS 4

// Read latency of byte_ram in clocks
`define CM_MEM_LAT 2

// Clocks per cassette bit
`define CM_BIT_DIV 8

`endif

// ==== cas_mem_pkg.sv ====
// Types shared by the loader, the player, the arbiter and the RAM
// Widths come from cas_mem_defines.svh

`default_nettype none

`include "cas_mem_defines.svh"

package cas_mem_pkg;

   typedef logic [`CM_ADDR_W-1:0] mem_addr_t;
   typedef logic [`CM_DATA_W-1:0] mem_data_t;

   // Holds 0 .. CM_CREDITS inclusive
   typedef logic [$clog2(`CM_CREDITS+1)-1:0] cred_cnt_t;

   // One host download beat
   typedef struct packed {
      mem_addr_t addr;
      mem_data_t data;
   } dl_beat_t;

   // One memory request, data is ignored on reads
   typedef struct packed {
      mem_addr_t addr;
      mem_data_t data;
      logic      we;
   } mem_req_t;

   typedef enum logic [1:0] {
      TP_IDLE,
      TP_RUN,
      TP_PAUSED
   } tape_state_e;

endpackage

`default_nettype wire

// ==== upload_loader.sv ====
// Download loader: buffers host beats and turns them into memory writes
// The host must respect its CM_CREDITS credits, there is no overflow check
// dl_credit pulses one cycle after a beat leaves the FIFO

`timescale 1ns/1ps
`default_nettype none

`include "cas_mem_defines.svh"

module upload_loader (
   input  wire                           clock_bus,
   input  wire                           rst_n,
   input  wire                           dl_valid,
   input  wire  cas_mem_pkg::dl_beat_t   dl_beat,
   output logic                          dl_credit,
   output logic                          req_valid,
   output cas_mem_pkg::mem_req_t         req,
   input  wire                           req_credit
);

   localparam int PTR_W = $clog2(`CM_CREDITS);

   cas_mem_pkg::dl_beat_t  fifo [`CM_CREDITS];
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   cas_mem_pkg::cred_cnt_t fill;
   cas_mem_pkg::cred_cnt_t credits;
   logic                   pop;

   // Forward the head beat whenever the arbiter has room for it
   assign pop       = (fill != '0) && (credits != '0);
   assign req_valid = pop;

   always_comb begin
      req.addr = fifo[rd_ptr].addr;
      req.data = fifo[rd_ptr].data;
      req.we   = 1'b1;
   end

   always_ff @(posedge clock_bus) begin
      if (dl_valid) begin
         fifo[wr_ptr] <= dl_beat;
      end
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         fill      <= '0;
         credits   <= cas_mem_pkg::cred_cnt_t'(`CM_CREDITS);
         dl_credit <= 1'b0;
      end else begin
         if (dl_valid) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         fill    <= fill + cas_mem_pkg::cred_cnt_t'(dl_valid)
                         - cas_mem_pkg::cred_cnt_t'(pop);
         credits <= credits - cas_mem_pkg::cred_cnt_t'(pop)
                            + cas_mem_pkg::cred_cnt_t'(req_credit);
         // One host credit back per forwarded beat
         dl_credit <= pop;
      end
   end

endmodule

`default_nettype wire

// ==== tape_player.sv ====
// Cassette player: reads bytes from address 0 upward, shifts them out MSB first
// One cas_strobe every CM_BIT_DIV clocks while data is available
// Reads in flight plus buffered bytes never exceed CM_CREDITS
// Rewind is a single-cycle pulse; play is a level

`timescale 1ns/1ps
`default_nettype none

`include "cas_mem_defines.svh"

module tape_player (
   input  wire                           clock_bus,
   input  wire                           rst_n,
   input  wire                           play,
   input  wire                           rewind,
   output logic                          req_valid,
   output cas_mem_pkg::mem_req_t         req,
   input  wire                           req_credit,
   input  wire                           rsp_valid,
   input  wire  cas_mem_pkg::mem_data_t  rsp_data,
   output logic                          cas_out,
   output logic                          cas_strobe
);

   localparam int PTR_W = $clog2(`CM_CREDITS);
   localparam int DIV_W = $clog2(`CM_BIT_DIV);
   localparam int BIT_W = $clog2(`CM_DATA_W);

   cas_mem_pkg::tape_state_e state;
   cas_mem_pkg::mem_addr_t   rd_addr;
   cas_mem_pkg::cred_cnt_t   credits;
   cas_mem_pkg::cred_cnt_t   pend;
   cas_mem_pkg::cred_cnt_t   drop;
   cas_mem_pkg::cred_cnt_t   buf_cnt;
   cas_mem_pkg::mem_data_t   bbuf [`CM_CREDITS];
   logic [PTR_W-1:0]         wr_ptr;
   logic [PTR_W-1:0]         rd_ptr;
   cas_mem_pkg::mem_data_t   shreg;
   cas_mem_pkg::mem_data_t   cur_byte;
   logic [BIT_W-1:0]         bits_left;
   logic [DIV_W-1:0]         div;
   logic                     room;
   logic                     issue;
   logic                     keep;
   logic                     tick;
   logic                     pop;

   // ==============================
   // Read prefetch
   // ==============================
   assign room  = ({1'b0, pend} + {1'b0, buf_cnt}) < `CM_CREDITS;
   assign issue = (state == cas_mem_pkg::TP_RUN) && !rewind && (credits != '0) && room;
   // Responses owed to a rewound stream are dropped
   assign keep  = rsp_valid && (drop == '0) && !rewind;

   assign req_valid = issue;

   always_comb begin
      req.addr = rd_addr;
      req.data = '0;
      req.we   = 1'b0;
   end

   // ==============================
   // Bit serializer
   // ==============================
   assign tick = (state == cas_mem_pkg::TP_RUN) && !rewind
              && (div == DIV_W'(`CM_BIT_DIV-1))
              && ((bits_left != '0) || (buf_cnt != '0));
   // Next byte taken straight from the buffer on its first bit
   assign pop      = tick && (bits_left == '0);
   assign cur_byte = pop ? bbuf[rd_ptr] : shreg;

   always_ff @(posedge clock_bus) begin
      if (keep) begin
         bbuf[wr_ptr] <= rsp_data;
      end
      if (tick) begin
         shreg <= {cur_byte[`CM_DATA_W-2:0], 1'b0};
      end
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         state <= cas_mem_pkg::TP_IDLE;
      end else begin
         case (state)
            cas_mem_pkg::TP_IDLE:   if (play) state <= cas_mem_pkg::TP_RUN;
            cas_mem_pkg::TP_RUN:    if (!play) state <= cas_mem_pkg::TP_PAUSED;
            cas_mem_pkg::TP_PAUSED: begin
               if (rewind) begin
                  state <= cas_mem_pkg::TP_IDLE;
               end else if (play) begin
                  state <= cas_mem_pkg::TP_RUN;
               end
            end
            default: state <= cas_mem_pkg::TP_IDLE;
         endcase
      end
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         rd_addr    <= '0;
         credits    <= cas_mem_pkg::cred_cnt_t'(`CM_CREDITS);
         pend       <= '0;
         drop       <= '0;
         buf_cnt    <= '0;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         bits_left  <= '0;
         div        <= '0;
         cas_out    <= 1'b0;
         cas_strobe <= 1'b0;
      end else begin
         pend    <= pend + cas_mem_pkg::cred_cnt_t'(issue)
                         - cas_mem_pkg::cred_cnt_t'(rsp_valid);
         credits <= credits - cas_mem_pkg::cred_cnt_t'(issue)
                            + cas_mem_pkg::cred_cnt_t'(req_credit);
         cas_strobe <= tick;
         if (tick) begin
            cas_out <= cur_byte[`CM_DATA_W-1];
         end
         if (rewind) begin
            // Everything still outstanding belongs to the old position
            rd_addr   <= '0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            buf_cnt   <= '0;
            bits_left <= '0;
            div       <= '0;
            drop      <= pend - cas_mem_pkg::cred_cnt_t'(rsp_valid);
         end else begin
            if (issue) begin
               rd_addr <= rd_addr + 1'b1;
            end
            if (keep) begin
               wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
               rd_ptr <= rd_ptr + 1'b1;
            end
            if (rsp_valid && (drop != '0)) begin
               drop <= drop - 1'b1;
            end
            buf_cnt <= buf_cnt + cas_mem_pkg::cred_cnt_t'(keep)
                               - cas_mem_pkg::cred_cnt_t'(pop);
            // Divider holds while paused or starved so no bit is lost
            if ((state == cas_mem_pkg::TP_RUN) && ((bits_left != '0) || (buf_cnt != '0))) begin
               div <= tick ? '0 : div + 1'b1;
            end
            if (tick) begin
               bits_left <= pop ? BIT_W'(`CM_DATA_W-1) : bits_left - 1'b1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
// Fixed-priority arbiter, the loader (peer 0) beats the player (peer 1)
// Each peer has a CM_CREDITS deep request queue, an empty queue is bypassed
// Credit comes back one cycle after the grant
// Only the player reads, so read data always goes to rsp_*

`timescale 1ns/1ps
`default_nettype none

`include "cas_mem_defines.svh"

module mem_arbiter (
   input  wire                           clock_bus,
   input  wire                           rst_n,
   input  wire                           ld_valid,
   input  wire  cas_mem_pkg::mem_req_t   ld_req,
   output logic                          ld_credit,
   input  wire                           tp_valid,
   input  wire  cas_mem_pkg::mem_req_t   tp_req,
   output logic                          tp_credit,
   output logic                          mem_valid,
   output cas_mem_pkg::mem_req_t         mem_req,
   input  wire                           rd_valid,
   input  wire  cas_mem_pkg::mem_data_t  rd_data,
   output logic                          rsp_valid,
   output cas_mem_pkg::mem_data_t        rsp_data
);

   localparam int PTR_W = $clog2(`CM_CREDITS);
   localparam int NP    = 2;

   cas_mem_pkg::mem_req_t  q_mem [NP][`CM_CREDITS];
   logic [PTR_W-1:0]       q_wr [NP];
   logic [PTR_W-1:0]       q_rd [NP];
   cas_mem_pkg::cred_cnt_t q_cnt [NP];
   cas_mem_pkg::mem_req_t  in_req [NP];
   cas_mem_pkg::mem_req_t  head_req [NP];
   logic [NP-1:0]          in_valid;
   logic [NP-1:0]          head_valid;
   logic [NP-1:0]          grant;
   logic [NP-1:0]          q_push;
   logic [NP-1:0]          q_pop;
   logic [NP-1:0]          credit_q;
   logic [`CM_MEM_LAT-1:0] rd_own;

   assign in_valid  = {tp_valid, ld_valid};
   assign in_req[0] = ld_req;
   assign in_req[1] = tp_req;

   // ==============================
   // Queue heads and grant
   // ==============================
   always_comb begin
      for (int p = 0; p < NP; p++) begin
         if (q_cnt[p] == '0) begin
            head_valid[p] = in_valid[p];
            head_req[p]   = in_req[p];
         end else begin
            head_valid[p] = 1'b1;
            head_req[p]   = q_mem[p][q_rd[p]];
         end
      end
      grant[0] = head_valid[0];
      grant[1] = head_valid[1] && !head_valid[0];
      for (int p = 0; p < NP; p++) begin
         // A request granted on arrival never enters the queue
         q_push[p] = in_valid[p] && !((q_cnt[p] == '0) && grant[p]);
         q_pop[p]  = grant[p] && (q_cnt[p] != '0);
      end
   end

   assign mem_valid = |head_valid;
   assign mem_req   = head_valid[0] ? head_req[0] : head_req[1];
   assign ld_credit = credit_q[0];
   assign tp_credit = credit_q[1];

   always_ff @(posedge clock_bus) begin
      for (int p = 0; p < NP; p++) begin
         if (q_push[p]) begin
            q_mem[p][q_wr[p]] <= in_req[p];
         end
      end
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         for (int p = 0; p < NP; p++) begin
            q_wr[p]  <= '0;
            q_rd[p]  <= '0;
            q_cnt[p] <= '0;
         end
         credit_q <= '0;
         rd_own   <= '0;
      end else begin
         for (int p = 0; p < NP; p++) begin
            if (q_push[p]) begin
               q_wr[p] <= q_wr[p] + 1'b1;
            end
            if (q_pop[p]) begin
               q_rd[p] <= q_rd[p] + 1'b1;
            end
            q_cnt[p] <= q_cnt[p] + cas_mem_pkg::cred_cnt_t'(q_push[p])
                                 - cas_mem_pkg::cred_cnt_t'(q_pop[p]);
         end
         credit_q <= grant;
         // Tracks which memory slots carry a read
         rd_own <= {rd_own[`CM_MEM_LAT-2:0], mem_valid && !mem_req.we};
      end
   end

   assign rsp_valid = rd_valid && rd_own[`CM_MEM_LAT-1];
   assign rsp_data  = rd_data;

endmodule

`default_nettype wire

// ==== byte_ram.sv ====
// Behavioral single-port byte RAM, one request per cycle
// A read accepted in cycle N returns rd_data in cycle N+CM_MEM_LAT
// Writes land at the accepting edge and return nothing

`timescale 1ns/1ps
`default_nettype none

`include "cas_mem_defines.svh"

module byte_ram (
   input  wire                           clock_bus,
   input  wire                           rst_n,
   input  wire                           mem_valid,
   input  wire  cas_mem_pkg::mem_req_t   mem_req,
   output logic                          rd_valid,
   output cas_mem_pkg::mem_data_t        rd_data
);

   cas_mem_pkg::mem_data_t mem [2**`CM_ADDR_W];
   cas_mem_pkg::mem_data_t pipe [`CM_MEM_LAT];
   logic [`CM_MEM_LAT-1:0] vld;

   // Array and data pipeline
   always_ff @(posedge clock_bus) begin
      if (mem_valid && mem_req.we) begin
         mem[mem_req.addr] <= mem_req.data;
      end
      pipe[0] <= mem[mem_req.addr];
      for (int i = 1; i < `CM_MEM_LAT; i++) begin
         pipe[i] <= pipe[i-1];
      end
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         vld <= '0;
      end else begin
         vld <= {vld[`CM_MEM_LAT-2:0], mem_valid && !mem_req.we};
      end
   end

   assign rd_valid = vld[`CM_MEM_LAT-1];
   assign rd_data  = pipe[`CM_MEM_LAT-1];

endmodule

`default_nettype wire

// ==== cas_mem_top.sv ====
// Cassette path top: loader and player share byte_ram through one arbiter
// Single clock domain on clock_bus

`timescale 1ns/1ps
`default_nettype none

module cas_mem_top (
   input  wire                           clock_bus,
   input  wire                           rst_n,
   input  wire                           dl_valid,
   input  wire  cas_mem_pkg::dl_beat_t   dl_beat,
   output logic                          dl_credit,
   input  wire                           play,
   input  wire                           rewind,
   output logic                          cas_out,
   output logic                          cas_strobe
);

   logic                   ld_valid;
   cas_mem_pkg::mem_req_t  ld_req;
   logic                   ld_credit;
   logic                   tp_valid;
   cas_mem_pkg::mem_req_t  tp_req;
   logic                   tp_credit;
   logic                   rsp_valid;
   cas_mem_pkg::mem_data_t rsp_data;
   logic                   mem_valid;
   cas_mem_pkg::mem_req_t  mem_req;
   logic                   rd_valid;
   cas_mem_pkg::mem_data_t rd_data;

   // ==============================
   // Peers
   // ==============================
   upload_loader u_loader (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .dl_valid   (dl_valid),
      .dl_beat    (dl_beat),
      .dl_credit  (dl_credit),
      .req_valid  (ld_valid),
      .req        (ld_req),
      .req_credit (ld_credit)
   );

   tape_player u_player (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .play       (play),
      .rewind     (rewind),
      .req_valid  (tp_valid),
      .req        (tp_req),
      .req_credit (tp_credit),
      .rsp_valid  (rsp_valid),
      .rsp_data   (rsp_data),
      .cas_out    (cas_out),
      .cas_strobe (cas_strobe)
   );

   // ==============================
   // Shared memory
   // ==============================
   mem_arbiter u_arb (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .ld_valid  (ld_valid),
      .ld_req    (ld_req),
      .ld_credit (ld_credit),
      .tp_valid  (tp_valid),
      .tp_req    (tp_req),
      .tp_credit (tp_credit),
      .mem_valid (mem_valid),
      .mem_req   (mem_req),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .rsp_valid (rsp_valid),
      .rsp_data  (rsp_data)
   );

   byte_ram u_ram (
      .clock_bus (clock_bus),
      .rst_n     (rst_n),
      .mem_valid (mem_valid),
      .mem_req   (mem_req),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data)
   );

endmodule

`default_nettype wire

// ==== cas_mem_props.sv ====
// Protocol assertions for cas_mem_top, attached with bind
// Outstanding credit counts are kept here, apart from the DUT counters

`timescale 1ns/1ps
`default_nettype none

module cas_mem_props (
   input wire clock_bus,
   input wire rst_n,
   input wire dl_valid,
   input wire dl_credit,
   input wire ld_valid,
   input wire ld_credit,
   input wire tp_valid,
   input wire tp_credit,
   input wire mem_valid,
   input wire cas_strobe
);

   logic [3:0] dl_out;
   logic [3:0] ld_out;
   logic [3:0] tp_out;

   // Credits spent minus credits returned, per link
   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         dl_out <= '0;
         ld_out <= '0;
         tp_out <= '0;
      end else begin
         dl_out <= dl_out + 4'(dl_valid) - 4'(dl_credit);
         ld_out <= ld_out + 4'(ld_valid) - 4'(ld_credit);
         tp_out <= tp_out + 4'(tp_valid) - 4'(tp_credit);
      end
   end

   dl_return_ok: assert property (@(posedge clock_bus) disable iff (!rst_n)
      dl_credit |-> (dl_out != '0))
      else $error("dl_credit returned with no host beat outstanding");

   ld_return_ok: assert property (@(posedge clock_bus) disable iff (!rst_n)
      ld_credit |-> (ld_out != '0))
      else $error("loader credit returned with no request outstanding");

   tp_return_ok: assert property (@(posedge clock_bus) disable iff (!rst_n)
      tp_credit |-> (tp_out != '0))
      else $error("player credit returned with no request outstanding");

   // Every memory request is one grant, seen as one credit a cycle later
   mem_has_grant: assert property (@(posedge clock_bus) disable iff (!rst_n)
      mem_valid |=> $onehot({ld_credit, tp_credit}))
      else $error("memory request without exactly one grant");

   credit_from_grant: assert property (@(posedge clock_bus) disable iff (!rst_n)
      (ld_credit || tp_credit) |-> $past(mem_valid))
      else $error("credit returned without a memory grant before it");

   strobe_pulse: assert property (@(posedge clock_bus) disable iff (!rst_n)
      cas_strobe |=> !cas_strobe)
      else $error("cas_strobe held high for more than one cycle");

endmodule

`default_nettype wire

// ==== tb_cas_mem.sv ====
// Testbench for cas_mem_top driven by cas_mem_patterns.txt
// Commands are load, play, stop, rewind, wait <bits>, idle <cycles> and credits <count>
// Only loaded bytes are known, so a pattern must never play past its loaded image
// The watchdog allows 400 cycles per pattern line

`timescale 1ns/1ps
`default_nettype none

`include "cas_mem_defines.svh"

module tb_cas_mem;

   logic                   clock_bus = 1'b0;
   logic                   rst_n;
   logic                   dl_valid;
   cas_mem_pkg::dl_beat_t  dl_beat;
   logic                   dl_credit;
   logic                   play;
   logic                   rewind;
   logic                   cas_out;
   logic                   cas_strobe;

   // Reference image built from the load commands
   cas_mem_pkg::mem_data_t ref_mem [2**`CM_ADDR_W];
   bit                     ref_known [2**`CM_ADDR_W];

   integer                 seed = 4745;
   int                     beats_sent = 0;
   int                     credits_back = 0;
   int                     bits_seen = 0;
   int                     play_addr = 0;
   int                     nbits = 0;
   int                     wd_limit = 0;
   bit                     play_seen = 1'b0;
   bit                     run_done = 1'b0;
   cas_mem_pkg::mem_data_t shift_in = '0;

   always #2 clock_bus = ~clock_bus;

   cas_mem_top dut0 (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .dl_valid   (dl_valid),
      .dl_beat    (dl_beat),
      .dl_credit  (dl_credit),
      .play       (play),
      .rewind     (rewind),
      .cas_out    (cas_out),
      .cas_strobe (cas_strobe)
   );

   bind cas_mem_top cas_mem_props u_props (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .dl_valid   (dl_valid),
      .dl_credit  (dl_credit),
      .ld_valid   (ld_valid),
      .ld_credit  (ld_credit),
      .tp_valid   (tp_valid),
      .tp_credit  (tp_credit),
      .mem_valid  (mem_valid),
      .cas_strobe (cas_strobe)
   );

   // ==============================
   // Checks and error exit
   // ==============================
   task automatic stop_with_error(input string msg);
      run_done = 1'b1;
      $display("%s", msg);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_byte(input string what, input cas_mem_pkg::mem_data_t got,
                             input cas_mem_pkg::mem_data_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("FAIL time=%0t %s got=%02h expected=%02h",
                                   $time, what, got, exp));
      end
   endtask

   task automatic check_credits(input string what, input cas_mem_pkg::cred_cnt_t got,
                                input cas_mem_pkg::cred_cnt_t exp);
      if (got !== exp) begin
         stop_with_error($sformatf("FAIL time=%0t %s got=%0d expected=%0d",
                                   $time, what, got, exp));
      end
   endtask

   // Credits the host still holds
   function automatic cas_mem_pkg::cred_cnt_t host_credits();
      return cas_mem_pkg::cred_cnt_t'(`CM_CREDITS - (beats_sent - credits_back));
   endfunction

   // ==============================
   // Host side drivers
   // ==============================
   task automatic next_edge();
      @(posedge clock_bus);
      dl_valid <= 1'b0;
      rewind   <= 1'b0;
   endtask

   task automatic send_beat(input int addr, input int data);
      int gap;
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) next_edge();
      while (host_credits() == 0) next_edge();
      @(posedge clock_bus);
      dl_valid     <= 1'b1;
      dl_beat.addr <= cas_mem_pkg::mem_addr_t'(addr);
      dl_beat.data <= cas_mem_pkg::mem_data_t'(data);
      beats_sent++;
      ref_mem[addr]   = cas_mem_pkg::mem_data_t'(data);
      ref_known[addr] = 1'b1;
   endtask

   task automatic set_play(input logic on);
      next_edge();
      play <= on;
   endtask

   task automatic pulse_rewind();
      @(posedge clock_bus);
      dl_valid <= 1'b0;
      rewind   <= 1'b1;
      next_edge();
   endtask

   task automatic wait_bits(input int count);
      next_edge();
      while (bits_seen < count) next_edge();
   endtask

   task automatic wait_credits(input int count);
      int left;
      left = 64;
      next_edge();
      while ((host_credits() != count) && (left > 0)) begin
         next_edge();
         left--;
      end
      check_credits("host dl_credit count", host_credits(),
                    cas_mem_pkg::cred_cnt_t'(count));
   endtask

   // ==============================
   // Output monitor
   // ==============================
   always @(negedge clock_bus) begin
      if (!rst_n) begin
         if (dl_credit || cas_strobe || cas_out) begin
            stop_with_error("DUT outputs were not low during reset");
         end
      end else begin
         if (play) play_seen = 1'b1;
         if (dl_credit) begin
            if (credits_back >= beats_sent) begin
               stop_with_error("dl_credit came back with no host beat outstanding");
            end
            credits_back++;
         end
         if (cas_strobe) begin
            if (!play_seen) stop_with_error("cas_strobe pulsed before play was raised");
            shift_in = {shift_in[`CM_DATA_W-2:0], cas_out};
            nbits++;
            bits_seen++;
            if (nbits == `CM_DATA_W) begin
               if (!ref_known[play_addr]) begin
                  stop_with_error($sformatf("Tape played address %0d, which was never loaded",
                                            play_addr));
               end
               check_byte($sformatf("cas_out byte at address %0d", play_addr),
                          shift_in, ref_mem[play_addr]);
               play_addr++;
               nbits = 0;
            end
         end
         // Strobes after this edge belong to the restarted tape
         if (rewind) begin
            nbits     = 0;
            bits_seen = 0;
            play_addr = 0;
         end
      end
   end

   initial begin : watchdog
      wait (wd_limit != 0);
      repeat (wd_limit) @(posedge clock_bus);
      stop_with_error($sformatf("Watchdog expired after %0d cycles without finishing",
                                wd_limit));
   end

   // ==============================
   // Pattern sequencer
   // ==============================
   initial begin : sequencer
      int    fd;
      int    n;
      int    lines;
      int    a1;
      int    a2;
      string line;
      string op;
      rst_n    <= 1'b1;
      dl_valid <= 1'b0;
      dl_beat  <= '0;
      play     <= 1'b0;
      rewind   <= 1'b0;
      fd = $fopen("cas_mem_patterns.txt", "r");
      if (fd == 0) stop_with_error("Cannot open cas_mem_patterns.txt");
      lines = 0;
      while ($fgets(line, fd) != 0) lines++;
      $fclose(fd);
      wd_limit = lines * 400 + 16;
      @(posedge clock_bus);
      rst_n <= 1'b0;
      repeat (16) @(posedge clock_bus);
      rst_n <= 1'b1;
      fd = $fopen("cas_mem_patterns.txt", "r");
      while ($fgets(line, fd) != 0) begin
         n = $sscanf(line, "%s", op);
         if ((n < 1) || (op.getc(0) == "#")) continue;
         if (op == "load") begin
            n = $sscanf(line, "%s %h %h", op, a1, a2);
            send_beat(a1, a2);
         end else begin
            n = $sscanf(line, "%s %d", op, a1);
            if (op == "play") set_play(1'b1);
            else if (op == "stop") set_play(1'b0);
            else if (op == "rewind") pulse_rewind();
            else if (op == "wait") wait_bits(a1);
            else if (op == "idle") repeat (a1) next_edge();
            else if (op == "credits") wait_credits(a1);
            else stop_with_error($sformatf("Unknown pattern command %s", op));
         end
      end
      $fclose(fd);
      next_edge();
      run_done = 1'b1;
      $display("STATUS: PASS");
      $finish;
   end

   // Catches a run stopped by an assertion
   final begin
      if (!run_done) begin
         $display("Simulation ended before the pattern file was finished");
         $display("STATUS: FAIL");
      end
   end

endmodule

`default_nettype wire

// ==== cas_mem_patterns.txt ====
# load <addr hex> <byte hex> | play | stop | rewind | idle <cycles>
# wait <bits since last rewind, decimal> | credits <expected host credits, decimal>
credits 4
load 000 a5
load 001 3c
load 002 0f
load 003 f0
load 004 81
load 005 7e
load 006 c3
load 007 5a
credits 4
play
wait 20
stop
idle 40
play
wait 36
rewind
wait 16
load 800 11
load 801 22
load 802 33
credits 4
wait 48
stop
rewind
play
wait 24
stop
credits 4

// ==== filelist.f ====
+incdir+.
cas_mem_pkg.sv
upload_loader.sv
tape_player.sv
mem_arbiter.sv
byte_ram.sv
cas_mem_top.sv
cas_mem_props.sv
tb_cas_mem.sv

// ==== Makefile ====
# Verilator flow for the cassette memory path testbench

VERILATOR  := verilator
FLAGS      := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_cas_mem
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := STATUS: FAIL
PASS_MSG   := STATUS: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
